// ==== common/lb_pkg.sv ====
// shared widths, limits, pixel/window/mask/dimension types and controller states
package lb_pkg;

  localparam int PIX_W    = 16;  // bits per pixel
  localparam int MAX_LINE = 64;  // widest line and tallest frame
  localparam int WIN_DIM  = 3;   // window edge
  localparam int WIN_TAPS = WIN_DIM * WIN_DIM;

  // column index must reach MAX_LINE-1
  localparam int COL_W = $clog2(MAX_LINE);
  // dimensions go up to MAX_LINE itself, row count one past the last row
  localparam int DIM_W = $clog2(MAX_LINE + 1);

  typedef logic [PIX_W-1:0] pixel_t;  // one pixel
  typedef logic [COL_W-1:0] col_t;  // column address into the line memories
  typedef logic [DIM_W-1:0] dim_t;  // line width, frame height, row counter

  // tap k at bits k*PIX_W upward
  // tap 3*i+j holds pixel (r-i, c-j), (r, c) being the newest pixel
  typedef logic [WIN_TAPS*PIX_W-1:0] win_t;

  typedef logic [WIN_TAPS-1:0] mask_t;  // one enable per tap

  // controller states
  typedef enum logic [1:0] {
    IDLE  = 2'd0,  // waiting for start
    RUN   = 2'd1,  // streaming pixels
    DRAIN = 2'd2   // last pixel in, last window still pending
  } lb_state_e;

endpackage

// ==== window/lb_line_store.sv ====
// two cascaded line memories giving the pixels one and two lines above
`timescale 1ns/1ps

module lb_line_store (
  input  logic           clk,
  input  lb_pkg::pixel_t pix_in,
  input  logic           accept,
  input  lb_pkg::col_t   col,
  output lb_pkg::pixel_t tap_up1,
  output lb_pkg::pixel_t tap_up2
);
  import lb_pkg::*;

  pixel_t line1_mem [MAX_LINE];  // previous line
  pixel_t line2_mem [MAX_LINE];  // line before that

  // read before write at the same column gives the word one line old
  assign tap_up1 = line1_mem[col];
  assign tap_up2 = line2_mem[col];

  // old line-1 word drops into line 2 as the new pixel replaces it
  // stale words from an earlier frame only reach masked or suppressed taps
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      line1_mem[col] <= pix_in;
      line2_mem[col] <= line1_mem[col];
    end
  end

endmodule

// ==== window/lb_window_regs.sv ====
// 3x3 window register array, one new column per accepted pixel
`timescale 1ns/1ps

module lb_window_regs (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           accept,
  input  lb_pkg::pixel_t pix_in,
  input  lb_pkg::pixel_t tap_up1,
  input  lb_pkg::pixel_t tap_up2,
  output lb_pkg::win_t   raw_window
);
  import lb_pkg::*;

  pixel_t taps    [WIN_TAPS];  // tap 3*i+j = pixel (r-i, c-j)
  pixel_t new_col [WIN_DIM];   // incoming column, newest row first

  assign new_col[0] = pix_in;
  assign new_col[1] = tap_up1;
  assign new_col[2] = tap_up2;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int k = 0; k < WIN_TAPS; k++)
        taps[k] <= '0;
    end
    else if (accept)
    begin
      for (int i = 0; i < WIN_DIM; i++)
      begin
        taps[WIN_DIM*i] <= new_col[i];  // column offset 0
        for (int j = 1; j < WIN_DIM; j++)
          taps[WIN_DIM*i+j] <= taps[WIN_DIM*i+j-1];  // age one column
      end
    end
  end

  // flatten, tap k at bits k*PIX_W
  for (genvar k = 0; k < WIN_TAPS; k++)
  begin : g_pack
    assign raw_window[k*PIX_W +: PIX_W] = taps[k];
  end

endmodule

// ==== hdl/lb_ctrl.sv ====
// controller: start/busy/done FSM, column/row counters, border flags, ready/valid
`timescale 1ns/1ps

module lb_ctrl (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         start,
  input  logic         pad_en,
  input  lb_pkg::dim_t line_length,
  input  lb_pkg::dim_t feat_length,
  input  logic         valid_in,
  input  logic         ready_out,
  output logic         ready_in,
  output logic         valid_out,
  output logic         busy,
  output logic         done,
  output logic         accept,
  output lb_pkg::col_t col,
  output logic         pad_mode,
  output logic         top0,      // held window anchored on row 0
  output logic         top1,      // held window anchored on row 1
  output logic         left0,     // held window anchored on column 0
  output logic         left1      // held window anchored on column 1
);
  import lb_pkg::*;

  lb_state_e state;
  dim_t      width_q;   // latched line_length
  dim_t      height_q;  // latched feat_length
  dim_t      row;       // row of the incoming pixel
  logic      taken;     // window handshake
  logic      col_last;
  logic      row_last;
  logic      keep;      // accepted pixel yields a window

  assign taken    = valid_out & ready_out;
  // accept only while running and the output slot is free or emptying
  assign ready_in = (state == RUN) & (~valid_out | ready_out);
  assign accept   = valid_in & ready_in;
  assign busy     = (state != IDLE);

  assign col_last = (dim_t'(col) == width_q - dim_t'(1));
  assign row_last = (row == height_q - dim_t'(1));
  // valid mode needs two full rows and columns behind the anchor
  assign keep     = pad_mode | ((row >= dim_t'(2)) & (col >= col_t'(2)));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      width_q  <= '0;
      height_q <= '0;
      pad_mode <= 1'b0;
      done     <= 1'b0;
    end
    else
    begin
      done <= 1'b0;  // single-cycle pulse
      case (state)
        IDLE:
        begin
          if (start)
          begin
            width_q  <= line_length;  // frame setup sampled here only
            height_q <= feat_length;
            pad_mode <= pad_en;
            state    <= RUN;
          end
        end
        RUN:
        begin
          if (accept && col_last && row_last)
            state <= DRAIN;  // last pixel in
        end
        DRAIN:
        begin
          // wait for the final window to leave
          if (!valid_out || taken)
          begin
            done  <= 1'b1;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // position counters and flags of the window now held
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      col   <= '0;
      row   <= '0;
      top0  <= 1'b0;
      top1  <= 1'b0;
      left0 <= 1'b0;
      left1 <= 1'b0;
    end
    else if (state == IDLE && start)
    begin
      col <= '0;  // new frame starts top-left
      row <= '0;
    end
    else if (accept)
    begin
      top0  <= (row == dim_t'(0));
      top1  <= (row == dim_t'(1));
      left0 <= (col == col_t'(0));
      left1 <= (col == col_t'(1));
      if (col_last)
      begin
        col <= '0;
        row <= row + dim_t'(1);
      end
      else
        col <= col + col_t'(1);
    end
  end

  // output valid, held until taken
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      valid_out <= 1'b0;
    else if (accept)
      valid_out <= keep;  // new window replaces or suppresses
    else if (taken)
      valid_out <= 1'b0;
  end

  // a window can only appear after a pixel accepted while running
  a_no_valid_from_idle: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(valid_out) |-> $past(state == RUN));

  // column pointer stays inside the configured line
  a_col_in_line: assert property (@(posedge clk) disable iff (!rst_n)
    (state != IDLE) |-> (dim_t'(col) < width_q));

endmodule

// ==== hdl/lb_edge_mask.sv ====
// border mask: 9-tap enable from position flags, zeroes taps outside the image
`timescale 1ns/1ps

module lb_edge_mask (
  input  lb_pkg::win_t raw_window,
  input  logic         pad_mode,
  input  logic         top0,
  input  logic         top1,
  input  logic         left0,
  input  logic         left1,
  output lb_pkg::win_t window
);
  import lb_pkg::*;

  logic [WIN_DIM-1:0] row_en;  // per row offset i
  logic [WIN_DIM-1:0] col_en;  // per column offset j
  mask_t              tap_mask;

  // offset i is outside when it reaches above row 0
  assign row_en[0] = 1'b1;
  assign row_en[1] = ~(pad_mode & top0);
  assign row_en[2] = ~(pad_mode & (top0 | top1));
  // same rule leftwards of column 0
  assign col_en[0] = 1'b1;
  assign col_en[1] = ~(pad_mode & left0);
  assign col_en[2] = ~(pad_mode & (left0 | left1));

  always_comb
  begin
    for (int i = 0; i < WIN_DIM; i++)
    begin
      for (int j = 0; j < WIN_DIM; j++)
        tap_mask[WIN_DIM*i+j] = row_en[i] & col_en[j];
    end
  end

  // masked taps read as zero
  for (genvar k = 0; k < WIN_TAPS; k++)
  begin : g_tap
    assign window[k*PIX_W +: PIX_W] = tap_mask[k] ? raw_window[k*PIX_W +: PIX_W] : '0;
  end

endmodule

// ==== hdl/lb_top.sv ====
// window generator top: controller, line memories, window registers and border mask
`timescale 1ns/1ps

module lb_top (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          start,        // one-cycle pulse, taken only when idle
  input  logic          pad_en,       // padding mode when high
  input  lb_pkg::dim_t  line_length,  // pixels per line
  input  lb_pkg::dim_t  feat_length,  // lines per frame
  input  lb_pkg::pixel_t pix_in,
  input  logic          valid_in,
  output logic          ready_in,
  output logic          valid_out,
  input  logic          ready_out,
  output lb_pkg::win_t  window,
  output logic          busy,
  output logic          done
);
  import lb_pkg::*;

  logic   accept;      // pixel handshake this cycle
  col_t   col;         // column of the incoming pixel
  logic   pad_mode;
  logic   top0;
  logic   top1;
  logic   left0;
  logic   left1;
  pixel_t tap_up1;     // same column, one line up
  pixel_t tap_up2;     // same column, two lines up
  win_t   raw_window;  // unmasked taps

  lb_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .pad_en      (pad_en),
    .line_length (line_length),
    .feat_length (feat_length),
    .valid_in    (valid_in),
    .ready_out   (ready_out),
    .ready_in    (ready_in),
    .valid_out   (valid_out),
    .busy        (busy),
    .done        (done),
    .accept      (accept),
    .col         (col),
    .pad_mode    (pad_mode),
    .top0        (top0),
    .top1        (top1),
    .left0       (left0),
    .left1       (left1)
  );

  lb_line_store u_line_store (
    .clk     (clk),
    .pix_in  (pix_in),
    .accept  (accept),
    .col     (col),
    .tap_up1 (tap_up1),
    .tap_up2 (tap_up2)
  );

  lb_window_regs u_window_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .accept     (accept),
    .pix_in     (pix_in),
    .tap_up1    (tap_up1),
    .tap_up2    (tap_up2),
    .raw_window (raw_window)
  );

  lb_edge_mask u_edge_mask (
    .raw_window (raw_window),
    .pad_mode   (pad_mode),
    .top0       (top0),
    .top1       (top1),
    .left0      (left0),
    .left1      (left1),
    .window     (window)
  );

endmodule

// ==== test/tb_lb_tasks.svh ====
// window model, frame fill, failure report, window compare and per-test run tasks
`ifndef TB_LB_TASKS_SVH
`define TB_LB_TASKS_SVH

// random pixels for a w x h frame
task automatic fill_frame(input int w, input int h);
  frame = new[w * h];
  for (int k = 0; k < w * h; k++)
    frame[k] = pixel_t'($random(seed));
endtask

// tap 3*i+j = pixel (r-i, c-j), zero outside the image
function automatic win_t model_window(input int r, input int c, input int w);
  win_t win;
  int   rr;
  int   cc;
  win = '0;
  for (int i = 0; i < 3; i++)
  begin
    for (int j = 0; j < 3; j++)
    begin
      rr = r - i;
      cc = c - j;
      if (rr >= 0 && cc >= 0)
        win[(3 * i + j) * PIX_W +: PIX_W] = frame[rr * w + cc];
    end
  end
  return win;
endfunction

task automatic report_failure(input string msg);
  $display("%s", msg);
  other_errors++;
endtask

// window on the bus against the model for anchor (r, c)
task automatic compare_window(input string name, input int r, input int c, input int w);
  win_t exp_win;
  exp_win = model_window(r, c, w);
  checks++;
  if (window !== exp_win)
  begin
    $display("error %s window row %0d col %0d: expected %h actual %h",
             name, r, c, exp_win, window);
    value_errors++;
  end
endtask

// one frame: start, stream with gaps and stalls, check windows, done and idle state
task automatic run_test(input int t);
  int   w;
  int   h;
  int   pad;
  int   gap;
  int   stall;
  int   total;
  int   pix_idx;     // next pixel to send
  int   taken_cnt;
  int   done_cnt;
  int   cyc;
  int   roll;
  int   pos;
  bit   hold;        // window was stalled last cycle
  bit   frame_end;
  win_t held;
  int   kept_q [$];  // raster index per kept window, oldest first

  w         = tests[t][T_W];
  h         = tests[t][T_H];
  pad       = tests[t][T_PAD];
  gap       = tests[t][T_GAP];
  stall     = tests[t][T_STALL];
  total     = w * h;
  pix_idx   = 0;
  taken_cnt = 0;
  done_cnt  = 0;
  cyc       = 0;
  hold      = 1'b0;
  frame_end = 1'b0;
  held      = '0;
  fill_frame(w, h);

  @(posedge clk);
  #1;
  start       = 1'b1;
  pad_en      = (pad != 0);
  line_length = dim_t'(w);
  feat_length = dim_t'(h);
  @(posedge clk);
  #1;

  while (!frame_end)
  begin
    start = (cyc == 3);  // restart attempt while busy, must be ignored
    if (cyc == 3)
    begin
      pad_en      = (pad == 0);
      line_length = dim_t'(3);
      feat_length = dim_t'(3);
    end
    roll      = {$random(seed)} % 100;
    valid_in  = (pix_idx < total) && (roll >= gap);
    pix_in    = (pix_idx < total) ? frame[pix_idx] : '0;
    roll      = {$random(seed)} % 100;
    ready_out = (roll >= stall);

    @(negedge clk);  // everything settled here
    if (hold)
    begin
      checks++;
      if (window !== held)
        report_failure($sformatf("%s: window changed while stalled", test_names[t]));
    end
    hold = valid_out && !ready_out;
    held = window;
    if (valid_out && ready_out)
    begin
      taken_cnt++;
      if (kept_q.size() == 0)
        report_failure($sformatf("%s: window taken with no pixel to anchor it",
                                 test_names[t]));
      else
      begin
        pos = kept_q.pop_front();
        compare_window(test_names[t], pos / w, pos % w, w);
      end
    end
    if (valid_in && ready_in)
    begin
      // valid mode keeps only anchors with two rows and columns behind
      if (pad != 0 || (pix_idx / w >= 2 && pix_idx % w >= 2))
        kept_q.push_back(pix_idx);
      pix_idx++;
    end
    if (done)
    begin
      done_cnt++;
      frame_end = 1'b1;
      checks++;
      if (busy)
        report_failure($sformatf("%s: busy still high with done", test_names[t]));
      if (pix_idx != total || kept_q.size() != 0)
        report_failure($sformatf("%s: done came before the frame was finished",
                                 test_names[t]));
    end
    cyc++;
    @(posedge clk);
    #1;
  end

  // idle after the frame, done must not repeat
  valid_in  = 1'b0;
  ready_out = 1'b1;
  repeat (3)
  begin
    @(negedge clk);
    checks++;
    if (done)
      done_cnt++;
    if (busy || ready_in || valid_out)
      report_failure($sformatf("%s: DUT not idle after done", test_names[t]));
    @(posedge clk);
    #1;
  end

  checks += 2;
  if (done_cnt != 1)
  begin
    $display("error %s done pulses: expected 1 actual %0d", test_names[t], done_cnt);
    value_errors++;
  end
  if (taken_cnt != tests[t][T_EXP])
  begin
    $display("error %s window count: expected %0d actual %0d",
             test_names[t], tests[t][T_EXP], taken_cnt);
    value_errors++;
  end
endtask

`endif

// ==== test/tb_lb_top.sv ====
// testbench top: clock, reset, test table, stimulus loop, checks, timeout, closing line
`timescale 1ns/1ps

module tb_lb_top;
  import lb_pkg::*;

  localparam int N_TESTS = 8;
  localparam int N_COLS  = 6;
  // table columns
  localparam int T_W     = 0;  // line width
  localparam int T_H     = 1;  // frame height
  localparam int T_PAD   = 2;  // 1 = padding mode
  localparam int T_GAP   = 3;  // valid_in gap chance, percent
  localparam int T_STALL = 4;  // ready_out stall chance, percent
  localparam int T_EXP   = 5;  // windows expected for the frame

  string test_names [N_TESTS] = '{
    "valid_3x3",
    "valid_5x7",
    "valid_64x4",
    "pad_4x3",
    "pad_stall_6x5",
    "valid_stall_8x6",
    "pad_stall_3x8",
    "valid_stall_7x3"
  };

  // valid mode expects (h-2)*(w-2), padding mode h*w
  int tests [N_TESTS][N_COLS] = '{
    //  w   h  pad gap stall exp
    '{  3,  3,  0,  0,  0,    1},
    '{  5,  7,  0,  0,  0,   15},
    '{ 64,  4,  0,  0,  0,  124},
    '{  4,  3,  1,  0,  0,   12},
    '{  6,  5,  1, 30, 40,   30},
    '{  8,  6,  0, 25, 50,   24},
    '{  3,  8,  1, 10, 20,   24},
    '{  7,  3,  0, 20, 30,    5}
  };

  logic   clk;
  logic   rst_n;
  logic   start;
  logic   pad_en;
  dim_t   line_length;
  dim_t   feat_length;
  pixel_t pix_in;
  logic   valid_in;
  logic   ready_in;
  logic   valid_out;
  logic   ready_out;
  win_t   window;
  logic   busy;
  logic   done;

  int     seed;          // $random state
  pixel_t frame [];      // current frame, raster order
  int     value_errors;
  int     other_errors;
  int     checks;
  int     cycles;        // since time zero
  int     limit;         // timeout in cycles

  lb_top dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .pad_en      (pad_en),
    .line_length (line_length),
    .feat_length (feat_length),
    .pix_in      (pix_in),
    .valid_in    (valid_in),
    .ready_in    (ready_in),
    .valid_out   (valid_out),
    .ready_out   (ready_out),
    .window      (window),
    .busy        (busy),
    .done        (done)
  );

  always #5 clk = ~clk;  // 10 ns period

  // run limit from the table
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= limit)
    begin
      $display("timeout after %0d cycles, the DUT never finished its frames", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  `include "tb_lb_tasks.svh"

  initial
  begin
    int limit_sum;

    limit_sum    = 0;
    seed         = 36952;
    value_errors = 0;
    other_errors = 0;
    checks       = 0;
    cycles       = 0;
    for (int t = 0; t < N_TESTS; t++)
      limit_sum += tests[t][T_W] * tests[t][T_H] * 4;  // 4 cycles per pixel
    limit = limit_sum + 100;

    clk         = 1'b0;
    rst_n       = 1'b0;
    start       = 1'b0;
    pad_en      = 1'b0;
    line_length = '0;
    feat_length = '0;
    pix_in      = '0;
    valid_in    = 1'b0;
    ready_out   = 1'b0;

    repeat (2) @(posedge clk);  // reset held 2 cycles
    #1;
    rst_n = 1'b1;

    @(negedge clk);
    checks++;
    if (valid_out !== 1'b0 || ready_in !== 1'b0 || busy !== 1'b0 || done !== 1'b0)
      report_failure("outputs not all low after reset");

    // frames back to back, widths and modes change each time
    for (int t = 0; t < N_TESTS; t++)
      run_test(t);

    $display("checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+test
common/lb_pkg.sv
window/lb_line_store.sv
window/lb_window_regs.sv
hdl/lb_ctrl.sv
hdl/lb_edge_mask.sv
hdl/lb_top.sv
test/tb_lb_top.sv

// ==== Makefile ====
# Verilator build and run of the window generator testbench

VERILATOR ?= verilator
TOP       ?= tb_lb_top
BUILD_DIR ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

# sources from the file list, headers tracked for rebuilds
SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard test/*.svh)
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)

# status comes from the pass line in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
